// ==== logic/bus_map_pkg.sv ====
package bus_map_pkg;

  // ==========================================================================
  // Wishbone word address map
  // ==========================================================================

  localparam int ADDR_WIDTH = 8;

  // Low address bits carry the register index
  localparam int ADDR_IDX_BITS = 5;

  typedef logic [ADDR_WIDTH-1:0] wb_addr_t;

  // Read window, one word per register
  localparam wb_addr_t ADDR_REG_BASE = 8'h00;

  // Operand A load
  localparam wb_addr_t ADDR_OPA = 8'h20;

  // Issue window, written data is operand B
  localparam wb_addr_t ADDR_ISSUE_BASE = 8'h40;

endpackage

// ==== logic/issue_unit.sv ====
`timescale 1ns/1ns

module issue_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  bus_map_pkg::wb_addr_t wb_adr_i,
  input  lane_cfg_pkg::data_t   wb_dat_i,
  output lane_cfg_pkg::data_t   wb_dat_o,
  output logic                  wb_ack_o,

  output logic                  iss_valid_o,
  output lane_cfg_pkg::reg_id_t iss_rd_o,
  output lane_cfg_pkg::data_t   iss_opa_o,
  output lane_cfg_pkg::data_t   iss_opb_o,

  input  logic                  retire_valid_i,
  input  lane_cfg_pkg::reg_id_t retire_rd_i,

  output lane_cfg_pkg::reg_id_t rd_sel_o,
  input  lane_cfg_pkg::data_t   rd_data_i
);

  logic                  req;
  logic                  sel_reg;
  logic                  sel_opa;
  logic                  sel_issue;
  logic                  read_reg;
  logic                  accept;
  logic                  issue_fire;
  lane_cfg_pkg::reg_id_t req_idx;
  lane_cfg_pkg::data_t   opa_q;

  lane_cfg_pkg::pend_cnt_t pend_cnt [lane_cfg_pkg::NUM_REGS];
  logic [lane_cfg_pkg::NUM_REGS-1:0] pend_inc;
  logic [lane_cfg_pkg::NUM_REGS-1:0] pend_dec;

  // ==========================================================================
  // Address decode
  // ==========================================================================

  // No new request while ack is out
  assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign req_idx = wb_adr_i[bus_map_pkg::ADDR_IDX_BITS-1:0];

  assign sel_reg =
    wb_adr_i[bus_map_pkg::ADDR_WIDTH-1:bus_map_pkg::ADDR_IDX_BITS] ==
    bus_map_pkg::ADDR_REG_BASE[bus_map_pkg::ADDR_WIDTH-1:bus_map_pkg::ADDR_IDX_BITS];
  assign sel_issue =
    wb_adr_i[bus_map_pkg::ADDR_WIDTH-1:bus_map_pkg::ADDR_IDX_BITS] ==
    bus_map_pkg::ADDR_ISSUE_BASE[bus_map_pkg::ADDR_WIDTH-1:bus_map_pkg::ADDR_IDX_BITS];
  assign sel_opa = wb_adr_i == bus_map_pkg::ADDR_OPA;

  // Reads wait until the register has nothing in flight
  assign read_reg   = req && !wb_we_i && sel_reg;
  assign accept     = req && (!read_reg || pend_cnt[req_idx] == '0);
  assign issue_fire = accept && wb_we_i && sel_issue && req_idx != '0;

  assign rd_sel_o = req_idx;

  // ==========================================================================
  // Scoreboard
  // ==========================================================================

  always_comb begin
    pend_inc = '0;
    pend_dec = '0;
    if (issue_fire) begin
      pend_inc[req_idx] = 1'b1;
    end
    if (retire_valid_i) begin
      pend_dec[retire_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < lane_cfg_pkg::NUM_REGS; i++) begin
        pend_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < lane_cfg_pkg::NUM_REGS; i++) begin
        // Issue and retire together leave the count as is
        case ({pend_inc[i], pend_dec[i]})
          2'b10:   pend_cnt[i] <= pend_cnt[i] + 1'b1;
          2'b01:   pend_cnt[i] <= pend_cnt[i] - 1'b1;
          default: pend_cnt[i] <= pend_cnt[i];
        endcase
      end
    end
  end

  // ==========================================================================
  // Ack, operand A and issue
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_ack_o    <= 1'b0;
      iss_valid_o <= 1'b0;
      opa_q       <= '0;
    end else begin
      wb_ack_o    <= accept;
      iss_valid_o <= issue_fire;
      if (accept && wb_we_i && sel_opa) begin
        opa_q <= wb_dat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    // Unmapped reads return zero
    if (accept && !wb_we_i) begin
      wb_dat_o <= read_reg ? rd_data_i : '0;
    end
    if (issue_fire) begin
      iss_rd_o  <= req_idx;
      iss_opa_o <= opa_q;
      iss_opb_o <= wb_dat_i;
    end
  end

endmodule

// ==== logic/lane_cfg_pkg.sv ====
package lane_cfg_pkg;

  // ==========================================================================
  // Execution lane sizing
  // ==========================================================================

  localparam int DATA_WIDTH = 32;

  // Register 0 is hardwired to zero
  localparam int NUM_REGS = 32;
  localparam int REG_ID_WIDTH = 5;

  // Multiply chain depth, one slice of operand B per stage
  localparam int EX_STAGES = 4;
  localparam int SLICE_WIDTH = DATA_WIDTH / EX_STAGES;

  // Holds up to EX_STAGES + 1 in-flight results
  localparam int PEND_CNT_WIDTH = 3;

  // ==========================================================================
  // Data types
  // ==========================================================================

  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef logic [REG_ID_WIDTH-1:0] reg_id_t;

  typedef logic [PEND_CNT_WIDTH-1:0] pend_cnt_t;

endpackage

// ==== logic/mul_lane_top.sv ====
`timescale 1ns/1ns

module mul_lane_top (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  bus_map_pkg::wb_addr_t wb_adr_i,
  input  lane_cfg_pkg::data_t   wb_dat_i,
  output lane_cfg_pkg::data_t   wb_dat_o,
  output logic                  wb_ack_o
);

  // Entry k feeds stage k, the last entry feeds writeback
  logic                  chain_valid [lane_cfg_pkg::EX_STAGES+1];
  lane_cfg_pkg::reg_id_t chain_rd    [lane_cfg_pkg::EX_STAGES+1];
  lane_cfg_pkg::data_t   chain_opa   [lane_cfg_pkg::EX_STAGES+1];
  lane_cfg_pkg::data_t   chain_opb   [lane_cfg_pkg::EX_STAGES+1];
  lane_cfg_pkg::data_t   chain_acc   [lane_cfg_pkg::EX_STAGES+1];

  logic                  retire_valid;
  lane_cfg_pkg::reg_id_t retire_rd;
  lane_cfg_pkg::reg_id_t rd_sel;
  lane_cfg_pkg::data_t   rd_data;

  issue_unit u_issue (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .iss_valid_o    (chain_valid[0]),
    .iss_rd_o       (chain_rd[0]),
    .iss_opa_o      (chain_opa[0]),
    .iss_opb_o      (chain_opb[0]),
    .retire_valid_i (retire_valid),
    .retire_rd_i    (retire_rd),
    .rd_sel_o       (rd_sel),
    .rd_data_i      (rd_data)
  );

  // Partial sum starts at zero
  assign chain_acc[0] = '0;

  for (genvar k = 0; k < lane_cfg_pkg::EX_STAGES; k++) begin : g_stage
    mul_step_stage #(
      .STAGE_IDX (k)
    ) u_stage (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (chain_valid[k]),
      .rd_i    (chain_rd[k]),
      .opa_i   (chain_opa[k]),
      .opb_i   (chain_opb[k]),
      .acc_i   (chain_acc[k]),
      .valid_o (chain_valid[k+1]),
      .rd_o    (chain_rd[k+1]),
      .opa_o   (chain_opa[k+1]),
      .opb_o   (chain_opb[k+1]),
      .acc_o   (chain_acc[k+1])
    );
  end

  writeback_regfile u_regfile (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (chain_valid[lane_cfg_pkg::EX_STAGES]),
    .rd_i           (chain_rd[lane_cfg_pkg::EX_STAGES]),
    .acc_i          (chain_acc[lane_cfg_pkg::EX_STAGES]),
    .rd_sel_i       (rd_sel),
    .rd_data_o      (rd_data),
    .retire_valid_o (retire_valid),
    .retire_rd_o    (retire_rd)
  );

endmodule

// ==== logic/mul_step_stage.sv ====
`timescale 1ns/1ns

module mul_step_stage #(
  parameter int STAGE_IDX = 0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  logic                  valid_i,
  input  lane_cfg_pkg::reg_id_t rd_i,
  input  lane_cfg_pkg::data_t   opa_i,
  input  lane_cfg_pkg::data_t   opb_i,
  input  lane_cfg_pkg::data_t   acc_i,

  output logic                  valid_o,
  output lane_cfg_pkg::reg_id_t rd_o,
  output lane_cfg_pkg::data_t   opa_o,
  output lane_cfg_pkg::data_t   opb_o,
  output lane_cfg_pkg::data_t   acc_o
);

  logic [lane_cfg_pkg::SLICE_WIDTH-1:0] slice;
  lane_cfg_pkg::data_t                  partial;

  // This stage's byte of operand B
  assign slice = opb_i[STAGE_IDX*lane_cfg_pkg::SLICE_WIDTH +: lane_cfg_pkg::SLICE_WIDTH];

  // Only the low word of the product is kept
  assign partial = (opa_i * lane_cfg_pkg::data_t'(slice)) <<
                   (STAGE_IDX * lane_cfg_pkg::SLICE_WIDTH);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_o  <= rd_i;
    opa_o <= opa_i;
    opb_o <= opb_i;
    acc_o <= acc_i + partial;
  end

endmodule

// ==== logic/writeback_regfile.sv ====
`timescale 1ns/1ns

module writeback_regfile (
  input  logic                  clk_i,
  input  logic                  rst_i,

  input  logic                  valid_i,
  input  lane_cfg_pkg::reg_id_t rd_i,
  input  lane_cfg_pkg::data_t   acc_i,

  input  lane_cfg_pkg::reg_id_t rd_sel_i,
  output lane_cfg_pkg::data_t   rd_data_o,

  output logic                  retire_valid_o,
  output lane_cfg_pkg::reg_id_t retire_rd_o
);

  lane_cfg_pkg::data_t regs [lane_cfg_pkg::NUM_REGS];

  // ==========================================================================
  // Write port
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < lane_cfg_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (valid_i) begin
      regs[rd_i] <= acc_i;
    end
  end

  // Retire report goes out with the write
  assign retire_valid_o = valid_i;
  assign retire_rd_o    = rd_i;

  // ==========================================================================
  // Read port
  // ==========================================================================

  always_comb begin
    if (rd_sel_i == '0) begin
      rd_data_o = '0;
    end else begin
      rd_data_o = regs[rd_sel_i];
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the multiply lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mul_lane_tb -f vlog.f -o mul_lane_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/mul_lane_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

// ==== tests/mul_lane_assert.sv ====
`timescale 1ns/1ns

module mul_lane_assert (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    wb_cyc_i,
  input logic                    wb_stb_i,
  input logic                    wb_ack_i,
  input logic                    retire_valid_i,
  input lane_cfg_pkg::pend_cnt_t retire_cnt_i
);

  // Ack only answers a live request
  ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_ack_i |-> wb_cyc_i && wb_stb_i)
    else $error("wb_ack_o high without cyc and stb");

  // Single-cycle ack pulse
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o held for more than one cycle");

  // A retire always finds its issue already counted
  no_underflow: assert property (@(posedge clk_i) disable iff (!rst_i)
    retire_valid_i |-> retire_cnt_i != '0)
    else $error("pending counter retired below zero");

endmodule

bind issue_unit mul_lane_assert u_assert (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .wb_cyc_i       (wb_cyc_i),
  .wb_stb_i       (wb_stb_i),
  .wb_ack_i       (wb_ack_o),
  .retire_valid_i (retire_valid_i),
  .retire_cnt_i   (pend_cnt[retire_rd_i])
);

// ==== tests/mul_lane_tb.sv ====
`timescale 1ns/1ns

module mul_lane_tb;

  localparam int ACK_TIMEOUT = 50;
  localparam int NUM_RANDOM_OPS = 300;

  logic                  clk_i;
  logic                  rst_i;
  logic                  wb_cyc_i;
  logic                  wb_stb_i;
  logic                  wb_we_i;
  bus_map_pkg::wb_addr_t wb_adr_i;
  lane_cfg_pkg::data_t   wb_dat_i;
  lane_cfg_pkg::data_t   wb_dat_o;
  logic                  wb_ack_o;

  // Reference model
  lane_cfg_pkg::data_t model_regs [lane_cfg_pkg::NUM_REGS];
  lane_cfg_pkg::data_t model_opa;

  integer                seed = 32'h189f_2cc8;
  int                    op;
  lane_cfg_pkg::reg_id_t rnd_reg;
  lane_cfg_pkg::data_t   rnd_data;

  mul_lane_top dut (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ==========================================================================
  // Bus master
  // ==========================================================================

  function automatic bus_map_pkg::wb_addr_t reg_addr(input lane_cfg_pkg::reg_id_t r);
    return bus_map_pkg::ADDR_REG_BASE + bus_map_pkg::wb_addr_t'(r);
  endfunction

  function automatic bus_map_pkg::wb_addr_t issue_addr(input lane_cfg_pkg::reg_id_t r);
    return bus_map_pkg::ADDR_ISSUE_BASE + bus_map_pkg::wb_addr_t'(r);
  endfunction

  // Request held until ack, sampled on the falling edge
  task automatic bus_cycle(input logic we, input bus_map_pkg::wb_addr_t adr,
                           input lane_cfg_pkg::data_t dat,
                           output lane_cfg_pkg::data_t rdat);
    int waited;
    waited = 0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      waited++;
      if (waited > ACK_TIMEOUT) begin
        $display("TEST FAILED");
        $fatal(1, "No Wishbone ack within %0d cycles for address %h", ACK_TIMEOUT, adr);
      end
      @(negedge clk_i);
    end
    rdat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input bus_map_pkg::wb_addr_t adr, input lane_cfg_pkg::data_t dat);
    lane_cfg_pkg::data_t unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input bus_map_pkg::wb_addr_t adr, output lane_cfg_pkg::data_t dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  // ==========================================================================
  // Model updates and checks
  // ==========================================================================

  task automatic check_data(input lane_cfg_pkg::data_t got, input lane_cfg_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic load_opa(input lane_cfg_pkg::data_t a);
    wb_write(bus_map_pkg::ADDR_OPA, a);
    model_opa = a;
  endtask

  task automatic issue_mul(input lane_cfg_pkg::reg_id_t r, input lane_cfg_pkg::data_t b);
    wb_write(issue_addr(r), b);
    if (r != '0) begin
      model_regs[r] = model_opa * b;
    end
  endtask

  task automatic read_reg_check(input lane_cfg_pkg::reg_id_t r, input string what);
    lane_cfg_pkg::data_t got;
    wb_read(reg_addr(r), got);
    check_data(got, model_regs[r], $sformatf("%s, register %0d", what, r));
  endtask

  task automatic check_all_regs(input string what);
    for (int i = 0; i < lane_cfg_pkg::NUM_REGS; i++) begin
      read_reg_check(lane_cfg_pkg::reg_id_t'(i), what);
    end
  endtask

  task automatic unmapped_read_check(input bus_map_pkg::wb_addr_t adr);
    lane_cfg_pkg::data_t got;
    wb_read(adr, got);
    check_data(got, '0, $sformatf("unmapped read at %h", adr));
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    rst_i    <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    model_opa = '0;
    for (int i = 0; i < lane_cfg_pkg::NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b1;

    check_all_regs("after reset");

    load_opa(32'h0001_2345);
    issue_mul(5'd3, 32'h0000_0100);
    read_reg_check(5'd3, "single issue");

    // Read straight after issue must see the new product
    issue_mul(5'd7, 32'h0000_1111);
    read_reg_check(5'd7, "first product");
    load_opa(32'hdead_beef);
    issue_mul(5'd7, 32'hcafe_f00d);
    read_reg_check(5'd7, "read after issue");

    // Several results in flight
    load_opa(32'h8765_4321);
    issue_mul(5'd10, 32'h0000_0003);
    issue_mul(5'd11, 32'hffff_ffff);
    issue_mul(5'd12, 32'h1234_5678);
    issue_mul(5'd12, 32'h0f0f_0f0f);
    issue_mul(5'd12, 32'h8000_0001);
    read_reg_check(5'd12, "same register back to back");
    read_reg_check(5'd10, "different registers");
    read_reg_check(5'd11, "different registers");

    // Register 0 and unmapped addresses
    issue_mul(5'd0, 32'h5555_aaaa);
    wb_write(8'h21, 32'h1357_9bdf);
    wb_write(8'h80, 32'h2468_ace0);
    wb_write(8'hff, 32'hffff_ffff);
    unmapped_read_check(8'h25);
    unmapped_read_check(8'h60);
    unmapped_read_check(8'hc3);
    issue_mul(5'd20, 32'h0000_0007);
    check_all_regs("after unmapped accesses");

    for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
      op       = int'($unsigned($random(seed)) % 3);
      rnd_reg  = lane_cfg_pkg::reg_id_t'($random(seed));
      rnd_data = lane_cfg_pkg::data_t'($random(seed));
      case (op)
        0:       load_opa(rnd_data);
        1:       issue_mul(rnd_reg, rnd_data);
        default: read_reg_check(rnd_reg, $sformatf("random op %0d", n));
      endcase
    end
    check_all_regs("after random operations");

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== vlog.f ====
logic/lane_cfg_pkg.sv
logic/bus_map_pkg.sv
logic/issue_unit.sv
logic/mul_step_stage.sv
logic/writeback_regfile.sv
logic/mul_lane_top.sv
tests/mul_lane_assert.sv
tests/mul_lane_tb.sv
